// ==== rtl/sfm_cfg.svh ====
`ifndef SFM_CFG_SVH
`define SFM_CFG_SVH

// Lane count must be a power of two from 2 to 8
`define SFM_LANES 4

`define SFM_ADD_W 16
`define SFM_FRAC_W 8
`define SFM_ACC_W 24

// Wide enough for the sum of all lanes
`define SFM_SUM_W (`SFM_ACC_W + $clog2(`SFM_LANES))

`endif

// ==== rtl/sfm_types_pkg.sv ====
`include "sfm_cfg.svh"

package sfm_types_pkg;

    localparam int unsigned DATA_W = (`SFM_ADD_W > `SFM_FRAC_W + 1) ?
                                     `SFM_ADD_W : `SFM_FRAC_W + 1;

    typedef logic [`SFM_ADD_W-1:0]          addend_t;
    typedef logic [`SFM_FRAC_W:0]           factor_t;   // Unsigned 1.FRAC_W format
    typedef logic [DATA_W-1:0]              data_t;
    typedef logic [`SFM_ACC_W-1:0]          acc_t;
    typedef logic [`SFM_SUM_W-1:0]          sum_t;
    typedef logic [$clog2(`SFM_LANES)-1:0]  lane_idx_t;

endpackage

// ==== rtl/sfm_ctrl_pkg.sv ====
package sfm_ctrl_pkg;

    typedef enum logic [1:0] {
        OP_ADD    = 2'd0,
        OP_SCALE  = 2'd1,
        OP_REDUCE = 2'd2
    } sfm_op_e;

    typedef enum logic {LANE_ADD = 1'b0, LANE_SCALE = 1'b1} lane_op_e;

    typedef enum logic [1:0] {ACCEPT, WAIT_IDLE, WAIT_DONE} disp_state_e;

    typedef enum logic [1:0] {IDLE, SUM, HOLD} drain_state_e;

endpackage

// ==== rtl/sfm_dispatch.sv ====
`timescale 1ns/10ps
`include "sfm_cfg.svh"

module sfm_dispatch
    import sfm_types_pkg::*;
    import sfm_ctrl_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  sfm_op_e               op_i,
    input  data_t                 data_i,
    input  logic                  valid_i,
    input  logic                  drain_done_i,
    output logic                  ready_o,
    output logic [`SFM_LANES-1:0] lane_en_o,
    output lane_op_e              lane_op_o,
    output data_t                 lane_data_o,
    output logic                  drain_start_o
);

    disp_state_e state_q, state_d;
    lane_idx_t   rr_q;
    logic        idle_cnt_q;
    logic        fire;
    logic        fire_add;
    logic        fire_scale;
    logic        fire_reduce;

    // ====================
    // Operation decode

    assign ready_o     = (state_q == ACCEPT);
    assign fire        = valid_i & ready_o;
    assign fire_add    = fire & (op_i == OP_ADD);
    assign fire_scale  = fire & (op_i == OP_SCALE);
    assign fire_reduce = fire & (op_i == OP_REDUCE);

    assign lane_op_o   = (op_i == OP_SCALE) ? LANE_SCALE : LANE_ADD;
    assign lane_data_o = data_i;

    always_comb begin
        lane_en_o = '0;
        if (fire_add) begin
            lane_en_o = {{(`SFM_LANES-1){1'b0}}, 1'b1} << rr_q;   // One lane per addend
        end else if (fire_scale) begin
            lane_en_o = '1;   // Factors reach every lane in stream order
        end
    end

    // ====================
    // Drain sequencing

    assign drain_start_o = (state_q == WAIT_IDLE) & idle_cnt_q;   // Lane pipes are empty here

    always_comb begin
        state_d = state_q;
        case (state_q)
            ACCEPT:    if (fire_reduce) state_d = WAIT_IDLE;
            WAIT_IDLE: if (idle_cnt_q) state_d = WAIT_DONE;
            WAIT_DONE: if (drain_done_i) state_d = ACCEPT;
            default:   state_d = ACCEPT;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= ACCEPT;
            rr_q       <= '0;
            idle_cnt_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            idle_cnt_q <= (state_q == WAIT_IDLE) & ~idle_cnt_q;
            if (fire_reduce) begin
                rr_q <= '0;   // Next row starts at lane 0
            end else if (fire_add) begin
                rr_q <= rr_q + 1'b1;   // Wraps since the lane count is a power of two
            end
        end
    end

endmodule

// ==== rtl/sfm_acc_lane.sv ====
`timescale 1ns/10ps
`include "sfm_cfg.svh"

module sfm_acc_lane
    import sfm_types_pkg::*;
    import sfm_ctrl_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     en_i,
    input  lane_op_e op_i,
    input  data_t    data_i,
    input  logic     clear_i,
    output acc_t     acc_o
);

    logic                          en_q;
    lane_op_e                      op_q;
    data_t                         data_q;
    acc_t                          acc_q;
    addend_t                       addend;
    factor_t                       factor;
    logic [`SFM_ACC_W+`SFM_FRAC_W:0] product;
    acc_t                          scaled;

    // ====================
    // Operation stage

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            en_q <= 1'b0;
        end else begin
            en_q <= en_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            op_q   <= op_i;
            data_q <= data_i;
        end
    end

    // ====================
    // Partial sum

    assign addend  = data_q[$bits(addend_t)-1:0];
    assign factor  = data_q[$bits(factor_t)-1:0];
    assign product = acc_q * factor;
    assign scaled  = acc_t'(product >> `SFM_FRAC_W);   // Truncating fixed-point rescale

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            acc_q <= '0;
        end else if (clear_i) begin
            acc_q <= '0;
        end else if (en_q) begin
            if (op_q == LANE_SCALE) begin
                acc_q <= scaled;
            end else begin
                acc_q <= acc_q + acc_t'(addend);
            end
        end
    end

    assign acc_o = acc_q;

endmodule

// ==== rtl/sfm_reduce.sv ====
`timescale 1ns/10ps
`include "sfm_cfg.svh"

module sfm_reduce
    import sfm_types_pkg::*;
    import sfm_ctrl_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    input  logic start_i,
    input  acc_t lanes_i [`SFM_LANES],
    input  logic ready_i,
    output sum_t result_o,
    output logic valid_o,
    output logic lane_clear_o,
    output logic done_o
);

    drain_state_e state_q, state_d;
    lane_idx_t    idx_q;
    sum_t         sum_q;
    logic         last_lane;
    logic         accept;

    assign last_lane = (idx_q == lane_idx_t'(`SFM_LANES - 1));
    assign valid_o   = (state_q == HOLD);
    assign accept    = valid_o & ready_i;
    assign result_o  = sum_q;

    // Total taken, so lanes start the next row from zero
    assign lane_clear_o = accept;
    assign done_o       = accept;

    // ====================
    // Drain FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start_i) state_d = SUM;
            SUM:     if (last_lane) state_d = HOLD;
            HOLD:    if (ready_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            idx_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == SUM) begin
                idx_q <= idx_q + 1'b1;   // Returns to 0 after the last lane
            end else begin
                idx_q <= '0;
            end
        end
    end

    // ====================
    // Sequential sum

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sum_q <= '0;
        end else if (state_q == IDLE && start_i) begin
            sum_q <= '0;
        end else if (state_q == SUM) begin
            sum_q <= sum_q + sum_t'(lanes_i[idx_q]);   // One lane per cycle
        end
    end

endmodule

// ==== rtl/sfm_acc_top.sv ====
`timescale 1ns/10ps
`include "sfm_cfg.svh"

module sfm_acc_top
    import sfm_types_pkg::*;
    import sfm_ctrl_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_ni,
    input  sfm_op_e op_i,
    input  data_t   data_i,
    input  logic    valid_i,
    input  logic    ready_i,
    output logic    ready_o,
    output sum_t    result_o,
    output logic    valid_o
);

    logic [`SFM_LANES-1:0] lane_en;
    lane_op_e              lane_op;
    data_t                 lane_data;
    logic                  lane_clear;
    logic                  drain_start;
    logic                  drain_done;
    acc_t                  lane_acc [`SFM_LANES];

    sfm_dispatch u_dispatch (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .op_i          (op_i),
        .data_i        (data_i),
        .valid_i       (valid_i),
        .drain_done_i  (drain_done),
        .ready_o       (ready_o),
        .lane_en_o     (lane_en),
        .lane_op_o     (lane_op),
        .lane_data_o   (lane_data),
        .drain_start_o (drain_start)
    );

    // ====================
    // Accumulation lanes

    for (genvar i = 0; i < `SFM_LANES; i++) begin : g_lane
        sfm_acc_lane u_lane (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .en_i    (lane_en[i]),
            .op_i    (lane_op),
            .data_i  (lane_data),
            .clear_i (lane_clear),
            .acc_o   (lane_acc[i])
        );
    end

    sfm_reduce u_reduce (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_i      (drain_start),
        .lanes_i      (lane_acc),
        .ready_i      (ready_i),
        .result_o     (result_o),
        .valid_o      (valid_o),
        .lane_clear_o (lane_clear),
        .done_o       (drain_done)
    );

endmodule

// ==== verification/tb_clkgen.sv ====
`timescale 1ns/10ps

module tb_clkgen #(
    parameter int unsigned PERIOD_NS  = 20,
    parameter int unsigned RST_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_no = 1'b1;   // Released just after an edge like the other inputs
    end

endmodule

// ==== verification/tb_sfm_acc.sv ====
`timescale 1ns/10ps
`include "sfm_cfg.svh"

module tb_sfm_acc
    import sfm_types_pkg::*;
    import sfm_ctrl_pkg::*;
();

    localparam string       GOLDEN_FILE     = "verification/sfm_golden.txt";
    localparam int unsigned CYCLES_PER_LINE = 20;
    localparam int unsigned TIMEOUT_BASE    = 100;

    logic        clk_i;
    logic        rst_ni;
    sfm_op_e     op_i;
    data_t       data_i;
    logic        valid_i;
    logic        ready_i;
    logic        ready_o;
    sum_t        result_o;
    logic        valid_o;

    int unsigned cycle_cnt = 0;
    int unsigned cycle_limit = 0;
    int unsigned totals_checked = 0;

    tb_clkgen #(.PERIOD_NS(20), .RST_CYCLES(3)) u_clkgen (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    sfm_acc_top uut (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .op_i     (op_i),
        .data_i   (data_i),
        .valid_i  (valid_i),
        .ready_i  (ready_i),
        .ready_o  (ready_o),
        .result_o (result_o),
        .valid_o  (valid_o)
    );

    // ====================
    // Checks

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_sum(input string name, input sum_t expected, input sum_t actual);
        if (actual !== expected) begin
            stop_run($sformatf("CHECK FAILED at time %0t: %s expected 0x%0h, got 0x%0h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic check_ready(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_run($sformatf("CHECK FAILED at time %0t: %s expected %b, got %b",
                               $time, name, expected, actual));
        end
    endtask

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            stop_run($sformatf("The run timed out after %0d clock cycles", cycle_cnt));
        end
    end

    // ====================
    // Drivers

    // Called 1 ns after a rising edge and returns at the same point of a later cycle
    task automatic send_op(input sfm_op_e op, input data_t data);
        logic taken;
        taken   = 1'b0;
        op_i    = op;
        data_i  = data;
        valid_i = 1'b1;
        while (!taken) begin
            @(negedge clk_i);
            taken = ready_o;
            @(posedge clk_i);
            #1;
        end
        valid_i = 1'b0;
    endtask

    task automatic collect_total(input sum_t expected);
        int unsigned stall;
        logic        seen;
        logic        taken;
        stall   = $urandom % 5 + 1;   // At least one cycle of back-pressure per total
        seen    = 1'b0;
        taken   = 1'b0;
        ready_i = 1'b0;
        while (!taken) begin
            @(negedge clk_i);
            check_ready("ready_o", 1'b0, ready_o);
            if (seen) begin
                check_ready("valid_o", 1'b1, valid_o);
                check_sum("result_o", expected, result_o);   // Must hold under back-pressure
            end else if (valid_o) begin
                seen = 1'b1;
                check_sum("result_o", expected, result_o);
            end
            taken = seen & ready_i;
            @(posedge clk_i);
            #1;
            if (seen && !taken) begin
                if (stall == 0) begin
                    ready_i = 1'b1;
                end else begin
                    stall--;
                end
            end
        end
        ready_i = 1'b0;
        @(negedge clk_i);
        check_ready("valid_o", 1'b0, valid_o);
        check_ready("ready_o", 1'b1, ready_o);
        @(posedge clk_i);
        #1;
        totals_checked++;
    endtask

    // ====================
    // Golden file replay

    initial begin
        int          fd;
        int          n;
        int unsigned line_cnt;
        string       line;
        logic [31:0] value;
        byte         code;
        logic        total_due;
        void'($urandom(32'h95bd_0e15));
        op_i      = OP_ADD;
        data_i    = '0;
        valid_i   = 1'b0;
        ready_i   = 1'b0;
        line_cnt  = 0;
        total_due = 1'b0;

        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            stop_run({"Could not open the golden file ", GOLDEN_FILE});
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0) line_cnt++;
        end
        $fclose(fd);
        cycle_limit = CYCLES_PER_LINE * line_cnt + TIMEOUT_BASE;

        @(posedge rst_ni);
        @(posedge clk_i);
        #1;
        check_ready("valid_o", 1'b0, valid_o);
        check_ready("ready_o", 1'b1, ready_o);

        fd = $fopen(GOLDEN_FILE, "r");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0) begin
                code  = line.getc(0);
                value = '0;
                n     = $sscanf(line.substr(1, line.len() - 1), "%h", value);
                if (code inside {"A", "S", "E"} && n != 1) begin
                    stop_run("A line of the golden file has no hex value");
                end
                case (code)
                    "A": send_op(OP_ADD, data_t'(value));
                    "S": send_op(OP_SCALE, data_t'(value));
                    "R": begin
                        send_op(OP_REDUCE, '0);
                        total_due = 1'b1;
                    end
                    "E": begin
                        if (!total_due) begin
                            stop_run("The golden file gives a total with no REDUCE before it");
                        end
                        collect_total(sum_t'(value));
                        total_due = 1'b0;
                    end
                    default: ;   // Comment or blank line
                endcase
            end
        end
        $fclose(fd);

        if (total_due || totals_checked == 0) begin
            stop_run("The golden file ended without a checked total");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/sfm_types_pkg.sv
rtl/sfm_ctrl_pkg.sv
rtl/sfm_dispatch.sv
rtl/sfm_acc_lane.sv
rtl/sfm_reduce.sv
rtl/sfm_acc_top.sv
verification/tb_clkgen.sv
verification/tb_sfm_acc.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in its output
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
    --top-module tb_sfm_acc -f sources.f -o sim_sfm_acc &&
./obj_dir/sim_sfm_acc | tee /dev/stderr | grep -x "No errors" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== verification/sfm_golden.txt ====
# Column 1: A add, S scale (factor 0x100 is 1.0), R reduce, E expected total
# Column 2: hex value (addend, factor or total), ignored for R
R 0
E 000000
A 0010
A 0020
A 0030
A 0040
A 0050
A 0060
R 0
E 000150
A 1000
A 0800
A 0301
S 0080
A 0007
A 0011
S 00c0
A 0100
R 0
E 000b31
A 1234
A 0567
S 0100
A 0089
R 0
E 001824
A 0abc
A 0def
S 0000
A 0042
R 0
E 000042
